/* Bender.yml */
package:
  name: mult_saxi_wr

sources:
  - hw/saxi_bus_pkg.sv
  - hw/wr_chn_pkg.sv
  - hw/chn_arbiter.sv
  - hw/burst_sequencer.sv
  - hw/beat_counter.sv
  - hw/chn_pointers.sv
  - hw/wdata_fifo.sv
  - hw/mult_saxi_wr.sv
  - target: test
    files:
      - bench/mult_saxi_wr_chk.sv
      - bench/tb_mult_saxi_wr.sv

/* bench/mult_saxi_wr_chk.sv */
//--------------------------------------------------------------------------
// bound into mult_saxi_wr; all checks are off while mclk is high
// en_chn_i is assumed steady from grant to read_burst
//--------------------------------------------------------------------------
module mult_saxi_wr_chk
    import saxi_bus_pkg::*;
    import wr_chn_pkg::*;
(
    input logic        aclk,
    input logic        mclk,
    input chn_mask_t   read_burst_o,
    input chn_mask_t   en_chn_i,
    input logic [31:0] awaddr_o,
    input logic        awvalid_o,
    input logic        awready_i,
    input data_t       wdata_o,
    input logic        wvalid_o,
    input logic        wready_i
);

    int fails = 0;                              // read by the testbench

    aw_hold: assert property (@(posedge aclk) disable iff (mclk)
        awvalid_o && !awready_i |=> awvalid_o && $stable(awaddr_o))
        else begin
            fails++;
            $error("awvalid or awaddr changed before awready");
        end

    w_hold: assert property (@(posedge aclk) disable iff (mclk)
        wvalid_o && !wready_i |=> wvalid_o && $stable(wdata_o))
        else begin
            fails++;
            $error("wvalid or wdata changed before wready");
        end

    rb_onehot: assert property (@(posedge aclk) disable iff (mclk)
        $onehot0(read_burst_o))
        else begin
            fails++;
            $error("read_burst_o has more than one bit set");
        end

    rb_enabled: assert property (@(posedge aclk) disable iff (mclk)
        (read_burst_o & ~en_chn_i) == '0)
        else begin
            fails++;
            $error("read_burst_o raised for a disabled channel");
        end

endmodule

bind mult_saxi_wr mult_saxi_wr_chk u_chk (.*);

/* bench/tb_mult_saxi_wr.sv */
//--------------------------------------------------------------------------
// directed tests; one source model serves all channels, since the DUT
// copies a single burst at a time. Run limit is MAX_CYCLES clock cycles
//--------------------------------------------------------------------------
module tb_mult_saxi_wr
    import saxi_bus_pkg::*;
    import wr_chn_pkg::*;
();

    localparam int MAX_CYCLES = 3000;   // five tests of up to ~600 cycles each

    logic aclk;
    logic mclk;
    chn_mask_t has_burst_i, read_burst_o, valid_chn_i, en_chn_i;
    data_t data_chn0_i, data_chn1_i, data_chn2_i, data_chn3_i;
    logic cfg_we_i;
    chn_t cfg_chn_i;
    word_addr_t cfg_start_i, cfg_len_i;
    logic [31:0] awaddr_o;
    axi_len_t awlen_o;
    axi_id_t awid_o, wid_o;
    logic awvalid_o, awready_i;
    data_t wdata_o;
    logic wlast_o, wvalid_o, wready_i;

    logic [41:0] aw_q [$];              // {awlen, awid, awaddr}
    logic [38:0] w_q [$];               // {wlast, wid, wdata}
    int avail [NUM_CHN];                // bursts a source still holds
    int sent [NUM_CHN];                 // bursts a source has sent
    word_addr_t cfg_start_m [NUM_CHN];  // host config as loaded
    int cfg_len_m [NUM_CHN];
    logic rand_ready;
    logic w_open = 1'b0;                // W is between first and last word of a burst
    logic [31:0] dly_lfsr = 32'h7673;
    logic [31:0] rdy_lfsr = 32'h7673;
    int cycles = 0;
    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;

    mult_saxi_wr u_mult_saxi_wr (.*);

    initial begin : clock_gen
        aclk = 1'b0;
        forever #10 aclk = ~aclk;
    end

    initial begin : watchdog
        while (cycles < MAX_CYCLES) begin
            @(posedge aclk);
            cycles++;
        end
        $display("timeout: run stopped after %0d cycles with traffic pending", cycles);
        $display("tests failed");
        $finish;
    end

    // galois form with taps of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    function automatic logic [31:0] word_val(input int c, input int n, input int k);
        return {c[7:0], n[15:0], k[7:0]};       // channel, burst, word
    endfunction

    task automatic drive_word(input int c, input data_t v);
        case (c)
            0: data_chn0_i <= v;
            1: data_chn1_i <= v;
            2: data_chn2_i <= v;
            default: data_chn3_i <= v;
        endcase
    endtask

    initial begin : source_model
        int c;
        int d;
        forever begin
            @(posedge aclk);
            if (!mclk && read_burst_o != '0) begin
                for (int i = 0; i < NUM_CHN; i++) begin
                    if (read_burst_o[i]) c = i;
                end
                avail[c] = avail[c] - 1;
                has_burst_i[c] <= (avail[c] != 0);  // falls after last burst
                d = 1;
                for (int i = 0; i < 2; i++) begin       // 1..4 cycles
                    d = d + (int'(dly_lfsr[0]) << i);
                    dly_lfsr = lfsr_next(dly_lfsr);
                end
                repeat (d - 1) @(posedge aclk);
                for (int k = 0; k < BURST_WORDS; k++) begin
                    @(posedge aclk);
                    drive_word(c, word_val(c, sent[c], k));
                    valid_chn_i[c] <= 1'b1;
                end
                @(posedge aclk);
                valid_chn_i <= '0;
                sent[c] = sent[c] + 1;
            end
        end
    end

    always @(posedge aclk) begin : axi_sink
        // sources send back to back, so a burst never runs dry on W
        if (mclk) begin
            w_open = 1'b0;
        end else if (w_open && !wvalid_o) begin
            $display("%0t: wvalid dropped between two words of one burst", $time);
            errors++;
        end
        if (awvalid_o && awready_i) aw_q.push_back({awlen_o, awid_o, awaddr_o});
        if (wvalid_o && wready_i) begin
            w_q.push_back({wlast_o, wid_o, wdata_o});
            w_open = !wlast_o;
        end
        if (rand_ready) begin
            awready_i <= rdy_lfsr[0];               // ~50% duty
            rdy_lfsr = lfsr_next(rdy_lfsr);
            wready_i <= rdy_lfsr[0];
            rdy_lfsr = lfsr_next(rdy_lfsr);
        end else begin
            awready_i <= 1'b1;
            wready_i  <= 1'b1;
        end
    end

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s: expected %h, got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic apply_reset();
        @(posedge aclk);
        mclk        <= 1'b1;
        has_burst_i <= '0;
        valid_chn_i <= '0;
        en_chn_i    <= '0;
        rand_ready  <= 1'b0;
        for (int c = 0; c < NUM_CHN; c++) begin
            avail[c] = 0;
            sent[c]  = 0;
        end
        repeat (2) @(posedge aclk);
        mclk <= 1'b0;
        aw_q.delete();
        w_q.delete();
    endtask

    task automatic configure(input int c, input word_addr_t start, input int len);
        @(posedge aclk);
        cfg_we_i    <= 1'b1;
        cfg_chn_i   <= chn_t'(c);
        cfg_start_i <= start;
        cfg_len_i   <= word_addr_t'(len);
        cfg_start_m[c] = start;
        cfg_len_m[c]   = len;
        @(posedge aclk);
        cfg_we_i <= 1'b0;
    endtask

    task automatic start_traffic(input chn_mask_t en, input int n [NUM_CHN]);
        @(posedge aclk);
        en_chn_i <= en;
        for (int c = 0; c < NUM_CHN; c++) begin
            avail[c] = n[c];
            has_burst_i[c] <= (n[c] != 0);
        end
    endtask

    task automatic wait_traffic(input int nb);
        while (aw_q.size() < nb || w_q.size() < nb * BURST_WORDS) @(posedge aclk);
        repeat (40) @(posedge aclk);                // catch stray beats
    endtask

    // bursts must arrive whole, in AW order, with ids as listed
    task automatic check_traffic(input int ids [$]);
        int off [NUM_CHN];
        int n [NUM_CHN];
        int c;
        logic [41:0] aw;
        logic [38:0] w;
        for (int i = 0; i < NUM_CHN; i++) begin
            off[i] = 0;
            n[i]   = 0;
        end
        if (aw_q.size() != ids.size() || w_q.size() != ids.size() * BURST_WORDS) begin
            $display("[FAIL] %0t traffic count: expected %0d AW / %0d W, got %0d / %0d",
                     $time, ids.size(), ids.size() * BURST_WORDS, aw_q.size(), w_q.size());
            errors++;
            return;
        end
        foreach (ids[b]) begin
            aw = aw_q[b];
            c  = ids[b];
            check_val("awid", aw[37:32], c);
            check_val("awlen", aw[41:38], BURST_WORDS - 1);
            check_val("awaddr", aw[31:0], {cfg_start_m[c] + word_addr_t'(off[c]), 2'b00});
            off[c] = off[c] + BURST_WORDS;
            if (off[c] >= cfg_len_m[c]) off[c] = 0;    // region wrap
            for (int k = 0; k < BURST_WORDS; k++) begin
                w = w_q[b * BURST_WORDS + k];
                check_val("wdata", w[31:0], word_val(c, n[c], k));
                check_val("wid", w[37:32], c);
                check_val("wlast", w[38], (k == BURST_WORDS - 1));
            end
            n[c]++;
        end
    endtask

    task automatic end_test(input string name, input int e0);
        tests_run++;
        if (errors == e0) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - e0);
        end
    endtask

    task automatic single_burst();
        int e0;
        e0 = errors;
        apply_reset();
        configure(0, 30'h100, 64);                  // byte address 0x400
        start_traffic(4'b0001, '{1, 0, 0, 0});
        wait_traffic(1);
        check_traffic({0});
        end_test("single_burst", e0);
    endtask

    task automatic pointer_wrap();
        int e0;
        e0 = errors;
        apply_reset();
        configure(2, 30'h2000, 32);                 // two bursts per region
        start_traffic(4'b0100, '{0, 0, 5, 0});
        wait_traffic(5);
        check_traffic({2, 2, 2, 2, 2});
        end_test("pointer_wrap", e0);
    endtask

    task automatic round_robin();
        int e0;
        e0 = errors;
        apply_reset();
        for (int c = 0; c < NUM_CHN; c++) configure(c, word_addr_t'(c * 'h1000), 64);
        start_traffic(4'b1111, '{2, 2, 2, 2});
        wait_traffic(8);
        check_traffic({0, 1, 2, 3, 0, 1, 2, 3});
        end_test("round_robin", e0);
    endtask

    task automatic channel_disable();
        int e0;
        e0 = errors;
        apply_reset();
        for (int c = 0; c < NUM_CHN; c++) configure(c, word_addr_t'(c * 'h1000), 64);
        start_traffic(4'b1101, '{2, 2, 2, 2});      // channel 1 keeps asking
        wait_traffic(6);
        check_traffic({0, 2, 3, 0, 2, 3});
        end_test("channel_disable", e0);
    endtask

    task automatic backpressure();
        int e0;
        int ids [$];
        e0 = errors;
        apply_reset();
        configure(0, 30'h0400, 48);
        configure(1, 30'h1400, 48);
        configure(3, 30'h3400, 48);
        rand_ready <= 1'b1;
        start_traffic(4'b1111, '{4, 4, 0, 4});
        for (int r = 0; r < 4; r++) ids = {ids, 0, 1, 3};
        wait_traffic(12);
        rand_ready <= 1'b0;
        check_traffic(ids);
        end_test("backpressure", e0);
    endtask

    initial begin : main
        int afails;
        mclk        = 1'b1;
        has_burst_i = '0;
        valid_chn_i = '0;
        en_chn_i    = '0;
        data_chn0_i = '0;
        data_chn1_i = '0;
        data_chn2_i = '0;
        data_chn3_i = '0;
        cfg_we_i    = 1'b0;
        cfg_chn_i   = '0;
        cfg_start_i = '0;
        cfg_len_i   = '0;
        awready_i   = 1'b0;
        wready_i    = 1'b0;
        rand_ready  = 1'b0;
        single_burst();
        pointer_wrap();
        round_robin();
        channel_disable();
        backpressure();
        afails = u_mult_saxi_wr.u_chk.fails;
        if (afails != 0) $display("bound checker reported %0d assertion failures", afails);
        $display("%0d tests run, %0d passed, %0d failed, %0d check errors",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (tests_failed == 0 && afails == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* hw/beat_counter.sv */
//--------------------------------------------------------------------------
// counts FIFO writes modulo the burst length
// relies on every source sending exactly one full burst per request
//--------------------------------------------------------------------------
module beat_counter
    import wr_chn_pkg::*;
(
    input  logic  aclk,
    input  logic  mclk,             // async reset, active high
    input  logic  beat_we_i,        // one word written to FIFO
    output beat_t beat_o,           // index of the word being written
    output logic  burst_done_o      // pulse on the final word
);

    localparam beat_t LAST_BEAT = beat_t'(BURST_WORDS - 1);

    assign burst_done_o = beat_we_i && (beat_o == LAST_BEAT);

    always_ff @(posedge aclk or posedge mclk) begin
        if (mclk) begin
            beat_o <= '0;
        end else if (beat_we_i) begin
            if (beat_o == LAST_BEAT) begin
                beat_o <= '0;                       // next burst
            end else begin
                beat_o <= beat_o + beat_t'(1);
            end
        end
    end

endmodule

/* hw/burst_sequencer.sv */
//--------------------------------------------------------------------------
// one burst at a time: grant, read_burst + AW beat, wait for the copy
// W data drains on its own, so earlier bursts may still be on the bus
//--------------------------------------------------------------------------
module burst_sequencer
    import wr_chn_pkg::*;
(
    input  logic      aclk,
    input  logic      mclk,             // async reset, active high
    input  logic      grant_i,          // arbiter pulse
    input  chn_t      chn_i,            // arbiter channel
    input  logic      has_room_i,       // FIFO can take a whole burst
    input  logic      burst_done_i,     // last word of burst written
    input  logic      awready_i,
    output logic      arb_en_o,
    output chn_mask_t read_burst_o,     // one-cycle, one-hot
    output logic      awvalid_o,
    output logic      aw_fire_o,        // AW transfer this cycle
    output chn_t      busy_chn_o        // channel being copied
);

    seq_state_t state;
    logic       aw_done;                // AW beat accepted
    logic       copy_done;              // all words in the FIFO
    logic       aw_end;
    logic       copy_end;

    assign aw_fire_o = awvalid_o && awready_i;
    assign arb_en_o  = (state == ARB) && has_room_i;

    // either already seen or happening right now
    assign aw_end   = aw_done || aw_fire_o;
    assign copy_end = copy_done || burst_done_i;

    always_ff @(posedge aclk or posedge mclk) begin
        if (mclk) begin
            state        <= IDLE;
            read_burst_o <= '0;
            awvalid_o    <= 1'b0;
            aw_done      <= 1'b0;
            copy_done    <= 1'b0;
            busy_chn_o   <= '0;
        end else begin
            read_burst_o <= '0;                     // default, pulse only
            if (aw_fire_o) begin
                awvalid_o <= 1'b0;
                aw_done   <= 1'b1;
            end
            if (burst_done_i) begin
                copy_done <= 1'b1;                  // may come before AW fires
            end

            case (state)
                IDLE: begin
                    if (has_room_i) begin
                        state <= ARB;
                    end
                end
                ARB: begin
                    if (grant_i) begin
                        state        <= REQ;
                        busy_chn_o   <= chn_i;
                        read_burst_o <= chn_mask_t'(1) << chn_i;
                        awvalid_o    <= 1'b1;       // rises with read_burst
                    end
                end
                REQ: begin
                    state <= COPY;
                end
                COPY: begin
                    if (aw_end && copy_end) begin
                        state <= DONE;
                    end
                end
                DONE: begin
                    aw_done   <= 1'b0;
                    copy_done <= 1'b0;
                    state     <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

/* hw/chn_arbiter.sv */
//--------------------------------------------------------------------------
// round-robin arbiter, search starts one past the last granted channel
// grant is a one-cycle pulse; chn_o holds until the next grant
//--------------------------------------------------------------------------
module chn_arbiter
    import wr_chn_pkg::*;
(
    input  logic      aclk,
    input  logic      mclk,         // async reset, active high
    input  chn_mask_t rq_i,         // ready and enabled channels
    input  logic      arb_en_i,     // from sequencer
    output logic      grant_o,      // single-cycle pulse
    output chn_t      chn_o         // granted channel, held
);

    chn_t pick;                     // next channel in rotation
    chn_t cand;
    logic found;

    // rotating priority, chn_o itself comes last
    always_comb begin
        pick  = chn_o;
        found = 1'b0;
        cand  = chn_o;
        for (int i = 1; i <= NUM_CHN; i++) begin
            cand = chn_o + chn_t'(i);                // wraps modulo NUM_CHN
            if (!found && rq_i[cand]) begin
                pick  = cand;
                found = 1'b1;
            end
        end
    end

    always_ff @(posedge aclk or posedge mclk) begin
        if (mclk) begin
            grant_o <= 1'b0;
            chn_o   <= chn_t'(NUM_CHN - 1);          // so channel 0 goes first
        end else begin
            // !grant_o keeps the pulse one cycle wide while arb_en lingers
            grant_o <= arb_en_i && found && !grant_o;
            if (arb_en_i && found && !grant_o) begin
                chn_o <= pick;
            end
        end
    end

endmodule

/* hw/chn_pointers.sv */
//--------------------------------------------------------------------------
// per-channel circular regions in word units; len must be a nonzero
// multiple of the burst, otherwise the pointer never wraps cleanly
//--------------------------------------------------------------------------
module chn_pointers
    import saxi_bus_pkg::*;
    import wr_chn_pkg::*;
(
    input  logic       aclk,
    input  logic       mclk,            // async reset, active high
    input  logic       cfg_we_i,        // load start/len, clear offset
    input  chn_t       cfg_chn_i,
    input  word_addr_t cfg_start_i,
    input  word_addr_t cfg_len_i,
    input  chn_t       chn_i,           // channel of the current burst
    input  logic       aw_fire_i,       // advance chn_i offset
    output word_addr_t awaddr_o         // start + offset of chn_i
);

    word_addr_t start_q [NUM_CHN];      // region base
    word_addr_t len_q   [NUM_CHN];      // region size
    word_addr_t offs_q  [NUM_CHN];      // next burst within region
    word_addr_t offs_nxt;

    assign awaddr_o = start_q[chn_i] + offs_q[chn_i];
    assign offs_nxt = offs_q[chn_i] + word_addr_t'(BURST_WORDS);

    // host config, no reset
    always_ff @(posedge aclk) begin
        if (cfg_we_i) begin
            start_q[cfg_chn_i] <= cfg_start_i;
            len_q[cfg_chn_i]   <= cfg_len_i;
        end
    end

    always_ff @(posedge aclk or posedge mclk) begin
        if (mclk) begin
            for (int i = 0; i < NUM_CHN; i++) begin
                offs_q[i] <= '0;
            end
        end else begin
            if (aw_fire_i) begin
                if (offs_nxt >= len_q[chn_i]) begin
                    offs_q[chn_i] <= '0;            // wrap to region start
                end else begin
                    offs_q[chn_i] <= offs_nxt;
                end
            end
            // config write wins over an advance on the same channel
            if (cfg_we_i) begin
                offs_q[cfg_chn_i] <= '0;
            end
        end
    end

endmodule

/* hw/mult_saxi_wr.sv */
//--------------------------------------------------------------------------
// 4-channel burst write engine, AW and W halves of an AXI slave port
// sources must send exactly 16 words per read_burst; no B channel
//--------------------------------------------------------------------------
module mult_saxi_wr
    import saxi_bus_pkg::*;
    import wr_chn_pkg::*;
(
    input  logic        aclk,
    input  logic        mclk,           // async reset, active high
    // sources
    input  chn_mask_t   has_burst_i,
    output chn_mask_t   read_burst_o,
    input  data_t       data_chn0_i,
    input  data_t       data_chn1_i,
    input  data_t       data_chn2_i,
    input  data_t       data_chn3_i,
    input  chn_mask_t   valid_chn_i,
    input  chn_mask_t   en_chn_i,
    // host config
    input  logic        cfg_we_i,
    input  chn_t        cfg_chn_i,
    input  word_addr_t  cfg_start_i,
    input  word_addr_t  cfg_len_i,
    // AW
    output logic [31:0] awaddr_o,       // byte address
    output axi_len_t    awlen_o,
    output axi_id_t     awid_o,
    output logic        awvalid_o,
    input  logic        awready_i,
    // W
    output data_t       wdata_o,
    output axi_id_t     wid_o,
    output logic        wlast_o,
    output logic        wvalid_o,
    input  logic        wready_i
);

    chn_mask_t  rq;
    logic       arb_en;
    logic       grant;
    chn_t       arb_chn;
    logic       has_room;
    logic       burst_done;
    logic       aw_fire;
    chn_t       busy_chn;
    data_t      chn_data [NUM_CHN];
    logic       beat_we;                // registered valid of busy channel
    data_t      wr_data_q;
    chn_t       wr_chn_q;
    beat_t      beat;
    chn_t       fifo_id;
    word_addr_t word_addr;

    assign rq = has_burst_i & en_chn_i;     // disabled channels never win

    assign chn_data[0] = data_chn0_i;
    assign chn_data[1] = data_chn1_i;
    assign chn_data[2] = data_chn2_i;
    assign chn_data[3] = data_chn3_i;

    // one register stage between the sources and the FIFO
    always_ff @(posedge aclk or posedge mclk) begin
        if (mclk) begin
            beat_we <= 1'b0;
        end else begin
            beat_we <= valid_chn_i[busy_chn];
        end
    end

    always_ff @(posedge aclk) begin
        wr_data_q <= chn_data[busy_chn];
        wr_chn_q  <= busy_chn;                      // travels as wid
    end

    assign awaddr_o = {word_addr, 2'b00};
    assign awlen_o  = axi_len_t'(BURST_WORDS - 1);
    assign awid_o   = axi_id_t'(busy_chn);
    assign wid_o    = axi_id_t'(fifo_id);

    chn_arbiter u_arbiter (
        .aclk     (aclk),
        .mclk     (mclk),
        .rq_i     (rq),
        .arb_en_i (arb_en),
        .grant_o  (grant),
        .chn_o    (arb_chn)
    );

    burst_sequencer u_sequencer (
        .aclk         (aclk),
        .mclk         (mclk),
        .grant_i      (grant),
        .chn_i        (arb_chn),
        .has_room_i   (has_room),
        .burst_done_i (burst_done),
        .awready_i    (awready_i),
        .arb_en_o     (arb_en),
        .read_burst_o (read_burst_o),
        .awvalid_o    (awvalid_o),
        .aw_fire_o    (aw_fire),
        .busy_chn_o   (busy_chn)
    );

    beat_counter u_beats (
        .aclk         (aclk),
        .mclk         (mclk),
        .beat_we_i    (beat_we),
        .beat_o       (beat),
        .burst_done_o (burst_done)
    );

    chn_pointers u_pointers (
        .aclk        (aclk),
        .mclk        (mclk),
        .cfg_we_i    (cfg_we_i),
        .cfg_chn_i   (cfg_chn_i),
        .cfg_start_i (cfg_start_i),
        .cfg_len_i   (cfg_len_i),
        .chn_i       (busy_chn),
        .aw_fire_i   (aw_fire),
        .awaddr_o    (word_addr)
    );

    wdata_fifo u_fifo (
        .aclk       (aclk),
        .mclk       (mclk),
        .we_i       (beat_we),
        .data_i     (wr_data_q),
        .last_i     (beat == beat_t'(BURST_WORDS - 1)),     // wlast on final index
        .id_i       (wr_chn_q),
        .re_i       (wvalid_o && wready_i),
        .data_o     (wdata_o),
        .last_o     (wlast_o),
        .id_o       (fifo_id),
        .nempty_o   (wvalid_o),
        .has_room_o (has_room)
    );

endmodule

/* hw/saxi_bus_pkg.sv */
//--------------------------------------------------------------------------
// memory-side bus field widths; addresses here count 32-bit words
// AWSIZE is fixed at 4 bytes, so byte address = word address << 2
//--------------------------------------------------------------------------
package saxi_bus_pkg;

    localparam int DATA_W  = 32;    // one bus word
    localparam int WADDR_W = 30;    // word address, byte address minus 2 lsbs
    localparam int ID_W    = 6;     // awid / wid
    localparam int LEN_W   = 4;     // AWLEN, bursts of up to 16 beats

    // word address, byte address without its two zero bits
    typedef logic [WADDR_W-1:0] word_addr_t;

    typedef logic [DATA_W-1:0]  data_t;     // write data word

    // channel number sits in the low bits, rest zero
    typedef logic [ID_W-1:0]    axi_id_t;

    typedef logic [LEN_W-1:0]   axi_len_t;  // beats minus one

endpackage

/* hw/wdata_fifo.sv */
//--------------------------------------------------------------------------
// show-ahead FIFO for W beats: data, wlast and channel id
// no overflow guard, writes are bounded by the has_room check
//--------------------------------------------------------------------------
module wdata_fifo
    import saxi_bus_pkg::*;
    import wr_chn_pkg::*;
#(
    parameter int DEPTH = FIFO_DEPTH    // at least BURST_WORDS
) (
    input  logic  aclk,
    input  logic  mclk,                 // async reset, active high
    input  logic  we_i,
    input  data_t data_i,
    input  logic  last_i,
    input  chn_t  id_i,
    input  logic  re_i,                 // only while nempty_o
    output data_t data_o,
    output logic  last_o,
    output chn_t  id_o,
    output logic  nempty_o,
    output logic  has_room_o            // one full burst fits
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    data_t            mem_data [DEPTH];
    logic             mem_last [DEPTH];
    chn_t             mem_id   [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;            // entries held

    assign data_o     = mem_data[rd_ptr];
    assign last_o     = mem_last[rd_ptr];
    assign id_o       = mem_id[rd_ptr];
    assign nempty_o   = (count != '0);
    assign has_room_o = (CNT_W'(DEPTH) - count) >= CNT_W'(BURST_WORDS);

    always_ff @(posedge aclk) begin
        if (we_i) begin
            mem_data[wr_ptr] <= data_i;
            mem_last[wr_ptr] <= last_i;
            mem_id[wr_ptr]   <= id_i;
        end
    end

    always_ff @(posedge aclk or posedge mclk) begin
        if (mclk) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (we_i) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
            end
            if (re_i) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
            end
            if (we_i && !re_i) begin
                count <= count + CNT_W'(1);
            end else if (re_i && !we_i) begin
                count <= count - CNT_W'(1);
            end
        end
    end

endmodule

/* hw/wr_chn_pkg.sv */
//--------------------------------------------------------------------------
// channel-side constants of the write engine
// burst is fixed at 16 words; FIFO must hold at least one burst
//--------------------------------------------------------------------------
package wr_chn_pkg;

    localparam int NUM_CHN  = 4;                // source channels
    localparam int CHN_W    = $clog2(NUM_CHN);

    typedef logic [CHN_W-1:0]   chn_t;          // channel number
    typedef logic [NUM_CHN-1:0] chn_mask_t;     // one bit per channel

    localparam int BURST_WORDS = 16;            // words per burst
    localparam int BEAT_W      = $clog2(BURST_WORDS);

    typedef logic [BEAT_W-1:0]  beat_t;         // index inside a burst

    localparam int FIFO_DEPTH  = 32;            // two bursts of W data

    // sequencer states
    typedef enum logic [2:0] {
        IDLE,   // wait for FIFO room
        ARB,    // arbiter enabled
        REQ,    // read_burst pulse, AW raised
        COPY,   // words moving into the FIFO
        DONE    // clear per-burst flags
    } seq_state_t;

endpackage

/* mult_saxi_wr.f */
hw/saxi_bus_pkg.sv
hw/wr_chn_pkg.sv
hw/chn_arbiter.sv
hw/burst_sequencer.sv
hw/beat_counter.sv
hw/chn_pointers.sv
hw/wdata_fifo.sv
hw/mult_saxi_wr.sv
bench/mult_saxi_wr_chk.sv
bench/tb_mult_saxi_wr.sv
